// ==== sim.f ====
source/capture_pkg.sv
source/sample_framer.sv
source/history_ram.sv
source/snapshot_reader.sv
source/capture_top.sv
tests/capture_assert.sv
tests/capture_tb.sv

// ==== source/capture_pkg.sv ====
// shared widths, history depth, beat structs and reader states; import in every capture module
package capture_pkg;

  //////////////////////////////////////////////////
  // widths and sizes
  //////////////////////////////////////////////////

  // one sample
  localparam int DATA_W = 16;
  // history slots
  localparam int DEPTH  = 16;
  // slot index / read offset
  localparam int ADDR_W = 4;
  // frame length in samples
  localparam int LEN_W  = 8;
  // sum of DEPTH samples cannot overflow this
  localparam int SUM_W  = DATA_W + ADDR_W;

  //////////////////////////////////////////////////
  // vector types
  //////////////////////////////////////////////////

  typedef logic [DATA_W-1:0] sample_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [LEN_W-1:0]  len_t;
  typedef logic [SUM_W-1:0]  sum_t;

  //////////////////////////////////////////////////
  // beats
  //////////////////////////////////////////////////

  // framer to history memory, last = frame end
  typedef struct packed {
    logic    valid;
    logic    last;
    sample_t data;
  } stream_beat_t;

  // reader to outside, last = final slot of snapshot
  typedef struct packed {
    logic    valid;
    logic    last;
    sample_t data;
  } readout_t;

  // snapshot reader FSM
  typedef enum logic [1:0] {
    IDLE,
    READ,
    DRAIN
  } reader_state_e;

endpackage

// ==== source/capture_top.sv ====
// top level of the capture path: framer into history memory, snapshot reader on the read side
`timescale 1ns/1ps

module capture_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  sample_valid,
  input  capture_pkg::sample_t  sample_data,
  input  capture_pkg::len_t     frame_len,
  input  logic                  trigger,
  output capture_pkg::readout_t readout,
  output capture_pkg::sum_t     snap_sum,
  output logic                  busy
);

  import capture_pkg::*;

  //////////////////////////////////////////////////
  // internal links
  //////////////////////////////////////////////////

  // framer to memory
  stream_beat_t beat;

  // reader to memory and back
  addr_t   rd_offset;
  sample_t rd_data;

  //////////////////////////////////////////////////
  // producer
  //////////////////////////////////////////////////

  // one beat per strobe, one cycle later
  sample_framer u_framer (
    .clk          (clk),
    .rst_n        (rst_n),
    .sample_valid (sample_valid),
    .sample_data  (sample_data),
    .frame_len    (frame_len),
    .beat         (beat)
  );

  //////////////////////////////////////////////////
  // buffer
  //////////////////////////////////////////////////

  // no write/read coherence, samples must pause during a readout
  history_ram u_history (
    .clk       (clk),
    .rst_n     (rst_n),
    .beat      (beat),
    .rd_offset (rd_offset),
    .rd_data   (rd_data)
  );

  //////////////////////////////////////////////////
  // consumer
  //////////////////////////////////////////////////

  // trigger to first readout 2 cycles, to last DEPTH+1
  snapshot_reader u_reader (
    .clk       (clk),
    .rst_n     (rst_n),
    .trigger   (trigger),
    .rd_offset (rd_offset),
    .rd_data   (rd_data),
    .readout   (readout),
    .snap_sum  (snap_sum),
    .busy      (busy)
  );

endmodule

// ==== source/history_ram.sv ====
// circular history memory: stores every beat, reads by offset from the oldest slot, clears on frame end
`timescale 1ns/1ps

module history_ram (
  input  logic                      clk,
  input  logic                      rst_n,
  input  capture_pkg::stream_beat_t beat,
  input  capture_pkg::addr_t        rd_offset,
  output capture_pkg::sample_t      rd_data
);

  import capture_pkg::*;

  //////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////

  // plain register array, no reset
  sample_t mem [DEPTH];

  // one flag per slot, set on write
  logic [DEPTH-1:0] slot_valid;

  // next slot to write, also the oldest slot once full
  addr_t wr_ptr;
  addr_t wr_ptr_inc;

  // read slot = (wr_ptr + offset) mod DEPTH
  logic [ADDR_W:0] slot_sum;
  addr_t           rd_slot;

  // registered read data
  sample_t rd_q;

  //////////////////////////////////////////////////
  // write pointer and flags
  //////////////////////////////////////////////////

  // wrap from DEPTH-1 back to 0
  assign wr_ptr_inc = (wr_ptr == addr_t'(DEPTH - 1)) ? '0 : wr_ptr + addr_t'(1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      slot_valid <= '0;
    end else if (beat.valid) begin
      if (beat.last) begin
        // frame end empties the history
        // the frame-end sample is written below but never flagged
        wr_ptr     <= '0;
        slot_valid <= '0;
      end else begin
        wr_ptr             <= wr_ptr_inc;
        slot_valid[wr_ptr] <= 1'b1;
      end
    end
  end

  // data write on every valid beat
  always_ff @(posedge clk) begin
    if (beat.valid) begin
      mem[wr_ptr] <= beat.data;
    end
  end

  //////////////////////////////////////////////////
  // offset read
  //////////////////////////////////////////////////

  // widen by one bit so the sum cannot wrap early
  assign slot_sum = {1'b0, wr_ptr} + {1'b0, rd_offset};

  always_comb begin
    if (slot_sum >= (ADDR_W + 1)'(DEPTH)) begin
      rd_slot = addr_t'(slot_sum - (ADDR_W + 1)'(DEPTH));
    end else begin
      rd_slot = addr_t'(slot_sum);
    end
  end

  // one cycle latency
  // nonblocking update means old contents are read
  // when a write hits the same slot in the same cycle
  always_ff @(posedge clk) begin
    if (slot_valid[rd_slot]) begin
      rd_q <= mem[rd_slot];
    end else begin
      // empty slot reads as zero
      rd_q <= '0;
    end
  end

  assign rd_data = rd_q;

endmodule

// ==== source/sample_framer.sv ====
// sample producer: registers raw sample strobes into beats and flags each frame end by count
`timescale 1ns/1ps

module sample_framer (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      sample_valid,
  input  capture_pkg::sample_t      sample_data,
  input  capture_pkg::len_t         frame_len,
  output capture_pkg::stream_beat_t beat
);

  import capture_pkg::*;

  //////////////////////////////////////////////////
  // frame position tracking
  //////////////////////////////////////////////////

  // samples already taken in the current frame
  len_t frame_cnt;
  // frame length latched at the first sample
  len_t len_q;
  // length that applies to the current sample
  len_t len_eff;
  logic frame_start;
  logic frame_end;

  // output beat fields
  logic    beat_valid;
  logic    beat_last;
  sample_t beat_data;

  // zero count means next sample opens a frame
  assign frame_start = (frame_cnt == '0);

  always_comb begin
    if (frame_start) begin
      // length 0 behaves as 1
      len_eff = (frame_len == '0) ? len_t'(1) : frame_len;
    end else begin
      len_eff = len_q;
    end
  end

  // count stays below len_eff, so +1 never overflows
  assign frame_end = ((frame_cnt + len_t'(1)) == len_eff);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frame_cnt <= '0;
      len_q     <= '0;
    end else if (sample_valid) begin
      if (frame_end) begin
        // restart, next sample latches a new length
        frame_cnt <= '0;
      end else begin
        frame_cnt <= frame_cnt + len_t'(1);
      end
      if (frame_start) begin
        len_q <= len_eff;
      end
    end
  end

  //////////////////////////////////////////////////
  // beat register
  //////////////////////////////////////////////////

  // strobe to beat in one cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_valid <= 1'b0;
      beat_last  <= 1'b0;
    end else begin
      beat_valid <= sample_valid;
      beat_last  <= sample_valid & frame_end;
    end
  end

  // payload, no reset
  always_ff @(posedge clk) begin
    if (sample_valid) begin
      beat_data <= sample_data;
    end
  end

  assign beat = '{valid: beat_valid, last: beat_last, data: beat_data};

endmodule

// ==== source/snapshot_reader.sv ====
// snapshot consumer that reads the whole history oldest first on trigger and reports its sum
`timescale 1ns/1ps

module snapshot_reader (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  trigger,
  output capture_pkg::addr_t    rd_offset,
  input  capture_pkg::sample_t  rd_data,
  output capture_pkg::readout_t readout,
  output capture_pkg::sum_t     snap_sum,
  output logic                  busy
);

  import capture_pkg::*;

  //////////////////////////////////////////////////
  // state
  //////////////////////////////////////////////////

  reader_state_e state;
  reader_state_e state_next;

  // offset presented to the memory
  addr_t offset_q;
  logic  last_offset;

  // read phase delayed by one marks memory data valid
  logic rd_phase_q;
  // final readout beat of the snapshot
  logic last_beat;

  // running sum and published sum
  sum_t acc_q;
  sum_t sum_q;
  sum_t sum_next;

  assign last_offset = (offset_q == addr_t'(DEPTH - 1));

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      // trigger only accepted here
      IDLE: begin
        if (trigger) begin
          state_next = READ;
        end
      end
      // one offset per cycle
      READ: begin
        if (last_offset) begin
          state_next = DRAIN;
        end
      end
      // last data still in flight
      DRAIN: begin
        state_next = IDLE;
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= IDLE;
      offset_q   <= '0;
      rd_phase_q <= 1'b0;
    end else begin
      state      <= state_next;
      rd_phase_q <= (state == READ);
      if (state == READ) begin
        // back to 0 after the newest slot
        offset_q <= last_offset ? '0 : offset_q + addr_t'(1);
      end
    end
  end

  //////////////////////////////////////////////////
  // sum
  //////////////////////////////////////////////////

  assign sum_next = acc_q + sum_t'(rd_data);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q <= '0;
      sum_q <= '0;
    end else begin
      if (state == IDLE && trigger) begin
        // fresh snapshot
        acc_q <= '0;
      end else if (rd_phase_q) begin
        acc_q <= sum_next;
      end
      if (last_beat) begin
        sum_q <= sum_next;
      end
    end
  end

  //////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////

  // data of offset DEPTH-1 lands while in DRAIN
  assign last_beat = (state == DRAIN);

  assign rd_offset = offset_q;
  assign readout   = '{valid: rd_phase_q, last: last_beat, data: rd_data};

  // new sum visible together with the last beat
  assign snap_sum = last_beat ? sum_next : sum_q;

  // t+1 through t+DEPTH+1
  assign busy = (state != IDLE);

endmodule

// ==== tests/capture_assert.sv ====
// bound checks on the snapshot reader for readout framing, busy flag and beats per snapshot
`timescale 1ns/1ps

module capture_assert (
  input logic                  clk,
  input logic                  rst_n,
  input capture_pkg::readout_t readout,
  input logic                  busy
);

  import capture_pkg::*;

  // readout beats seen since the previous last beat
  int beat_cnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_cnt <= 0;
    end else if (readout.valid) begin
      if (readout.last) begin
        beat_cnt <= 0;
      end else begin
        beat_cnt <= beat_cnt + 1;
      end
    end
  end

  //////////////////////////////////////////////////
  // properties
  //////////////////////////////////////////////////

  last_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
    readout.last |-> readout.valid)
    else $error("readout last asserted without readout valid");

  // reader goes idle right after the last beat
  idle_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
    readout.last |=> !busy)
    else $error("busy high while reader idle with no pending readout");

  // DEPTH beats per snapshot including the last one
  beats_per_snapshot: assert property (@(posedge clk) disable iff (!rst_n)
    readout.last |-> (beat_cnt == DEPTH - 1))
    else $error("snapshot did not carry DEPTH readout beats");

endmodule

bind snapshot_reader capture_assert u_assert (
  .clk     (clk),
  .rst_n   (rst_n),
  .readout (readout),
  .busy    (busy)
);

// ==== tests/capture_tb.sv ====
// testbench for capture_top that applies a table of sample runs and snapshots against a history model
`timescale 1ns/1ps

module capture_tb;

  import capture_pkg::*;

  localparam int NUM_ROWS = 10;

  // one stimulus row with samples to send, frame length, snapshot flag and retrigger flag
  typedef struct packed {
    logic [7:0] count;
    len_t       flen;
    logic       snap;
    logic       busy_trig;
  } row_t;

  logic     clk;
  logic     rst_n;
  logic     sample_valid;
  sample_t  sample_data;
  len_t     frame_len;
  logic     trigger;
  readout_t readout;
  sum_t     snap_sum;
  logic     busy;

  row_t rows [NUM_ROWS];

  // model of visible history oldest first
  sample_t hist_q [$];
  int      model_len;
  int      model_pos;
  sample_t exp_data [DEPTH];
  sum_t    exp_sum;
  sum_t    prev_sum;

  int   check_cnt;
  int   mismatch_cnt;
  int   cycle_cnt;
  int   cycle_limit;
  logic run_done;

  capture_top dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .sample_valid (sample_valid),
    .sample_data  (sample_data),
    .frame_len    (frame_len),
    .trigger      (trigger),
    .readout      (readout),
    .snap_sum     (snap_sum),
    .busy         (busy)
  );

  always #20 clk = ~clk;

  // run limit
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (!run_done && cycle_cnt >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Verification failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  // inputs change 1 ns after the rising edge
  task automatic tick;
    @(posedge clk);
    #1;
  endtask

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    check_cnt++;
    if (expected !== actual) begin
      mismatch_cnt++;
      $display("Mismatch at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
    end
  endtask

  function automatic row_t make_row(input int count, input int flen, input logic snap,
                                    input logic busy_trig);
    make_row = '{count: count[7:0], flen: len_t'(flen), snap: snap, busy_trig: busy_trig};
  endfunction

  task automatic load_table;
    // empty history right after reset
    rows[0] = make_row(0, 100, 1'b1, 1'b0);
    // partial fill inside a long frame
    rows[1] = make_row(5, 100, 1'b1, 1'b0);
    // wrap-around and a second trigger while busy
    rows[2] = make_row(20, 100, 1'b1, 1'b1);
    // reaches sample 100 so the frame closes
    rows[3] = make_row(75, 100, 1'b1, 1'b0);
    rows[4] = make_row(3, 4, 1'b1, 1'b0);
    rows[5] = make_row(1, 4, 1'b1, 1'b0);
    // length 0 acts as 1 so every sample ends a frame
    rows[6] = make_row(3, 0, 1'b0, 1'b0);
    rows[7] = make_row(7, 5, 1'b1, 1'b0);
    // length 5 still latched for the first 3 samples
    rows[8] = make_row(18, 30, 1'b1, 1'b1);
    rows[9] = make_row(0, 30, 1'b1, 1'b0);
  endtask

  // frame position follows the same rule as the framer
  task automatic model_push(input sample_t s);
    if (model_pos == 0) begin
      model_len = (frame_len == '0) ? 1 : int'(frame_len);
    end
    model_pos++;
    if (model_pos == model_len) begin
      hist_q.delete();
      model_pos = 0;
    end else begin
      hist_q.push_back(s);
      if (hist_q.size() > DEPTH) begin
        void'(hist_q.pop_front());
      end
    end
  endtask

  task automatic send_sample;
    sample_t s;
    s = sample_t'($urandom);
    sample_valid = 1'b1;
    sample_data  = s;
    model_push(s);
    tick();
  endtask

  // zeros for empty oldest slots followed by history in order
  task automatic predict;
    int pad;
    int o;
    pad     = DEPTH - hist_q.size();
    exp_sum = '0;
    for (o = 0; o < DEPTH; o++) begin
      if (o < pad) begin
        exp_data[o] = '0;
      end else begin
        exp_data[o] = hist_q[o - pad];
      end
      exp_sum = exp_sum + sum_t'(exp_data[o]);
    end
  endtask

  // k counts cycles after the trigger cycle
  task automatic run_snapshot(input logic busy_trig);
    int   k;
    logic exp_valid;
    predict();
    trigger = 1'b1;
    tick();
    for (k = 1; k <= DEPTH + 4; k++) begin
      trigger = busy_trig && (k == 5);
      @(negedge clk);
      exp_valid = (k >= 2) && (k <= DEPTH + 1);
      compare("busy", k <= DEPTH + 1, busy);
      compare("readout.valid", exp_valid, readout.valid);
      compare("readout.last", k == DEPTH + 1, readout.last);
      if (exp_valid) begin
        compare("readout.data", exp_data[k - 2], readout.data);
      end
      compare("snap_sum", (k >= DEPTH + 1) ? exp_sum : prev_sum, snap_sum);
      tick();
    end
    trigger  = 1'b0;
    prev_sum = exp_sum;
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    int r;
    int n;
    void'($urandom(10));
    clk          = 1'b0;
    rst_n        = 1'b0;
    sample_valid = 1'b0;
    sample_data  = '0;
    frame_len    = '0;
    trigger      = 1'b0;
    run_done     = 1'b0;
    check_cnt    = 0;
    mismatch_cnt = 0;
    cycle_cnt    = 0;
    model_pos    = 0;
    model_len    = 0;
    prev_sum     = '0;
    load_table();
    cycle_limit = 50;
    for (r = 0; r < NUM_ROWS; r++) begin
      cycle_limit = cycle_limit + int'(rows[r].count) + DEPTH + 8;
    end
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // quiet outputs after reset
    repeat (3) begin
      @(negedge clk);
      compare("busy", 0, busy);
      compare("readout.valid", 0, readout.valid);
      compare("readout.last", 0, readout.last);
      compare("snap_sum", 0, snap_sum);
    end
    tick();
    for (r = 0; r < NUM_ROWS; r++) begin
      frame_len = rows[r].flen;
      for (n = 0; n < int'(rows[r].count); n++) begin
        send_sample();
      end
      sample_valid = 1'b0;
      tick();
      if (rows[r].snap) begin
        run_snapshot(rows[r].busy_trig);
      end
    end
    run_done = 1'b1;
    $display("checks: %0d, mismatches: %0d", check_cnt, mismatch_cnt);
    if (mismatch_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
